// ==== sources.f ====
+incdir+.
game_pkg.sv
paddle_tracker.sv
hit_detector.sv
ball_controller.sv
game_top.sv
game_tb.sv

// ==== game_tb.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "game_consts.svh"

module game_tb;

    import game_pkg::*;

    localparam int test_period = 40;
    localparam int want_dir    = 0;
    localparam int want_x      = 1;
    localparam int want_floor  = 2;

    logic   clk_25MHZ = 1'b0;
    logic   reset;
    logic   game_start;
    logic   upscale;
    coord_t paddle_y;
    logic   paddle_valid;
    coord_t ball_x;
    coord_t ball_y;
    logic   is_ball_moving_left;

    int     error_count  = 0;
    int     tests_ok     = 0;
    int     tests_failing = 0;
    bit     timed_out    = 1'b0;
    bit     idle_check   = 1'b0;
    bit     hit_mode     = 1'b0;
    bit     miss_mode    = 1'b0;
    int     expected_gap = test_period + 1;

    int     cycle_count;
    int     last_move;
    bit     gap_valid;
    coord_t prev_x;
    logic   prev_left;
    bit     low_floor_seen;
    bit     high_floor_seen;

    game_top #(.base_period(test_period)) dut0 (.*);

    always #20 clk_25MHZ = ~clk_25MHZ;

    task automatic flag_error(input string msg);
        $display("[ERROR] %0t %s", $time, msg);
        error_count++;
    endtask

    ////////////////////////////////////////
    // checks
    ////////////////////////////////////////
    idle_hold: assert property (@(posedge clk_25MHZ) disable iff (reset)
        idle_check |-> (ball_x == 10'd100 && ball_y == 10'd80 && !is_ball_moving_left))
        else flag_error("ball left its start position while idle");

    start_left: assert property (@(posedge clk_25MHZ) disable iff (reset)
        $rose(game_start) |=> is_ball_moving_left)
        else flag_error("ball did not start moving left one cycle after game_start");

    x_step: assert property (@(posedge clk_25MHZ) disable iff (reset)
        (ball_x != $past(ball_x)) |-> (ball_x == ($past(is_ball_moving_left) ?
            $past(ball_x) - coord_t'(`BALL_STEP) : $past(ball_x) + coord_t'(`BALL_STEP))))
        else flag_error("ball_x moved by a wrong amount");

    step_gap: assert property (@(posedge clk_25MHZ) disable iff (reset)
        (gap_valid && ball_x != prev_x) |-> (cycle_count - last_move == expected_gap))
        else flag_error("cycles between steps differ from the expected gap");

    y_bound: assert property (@(posedge clk_25MHZ) disable iff (reset)
        ball_y <= (upscale ? coord_t'(`Y_MAX_HIGH) : coord_t'(`Y_MAX_LOW)))
        else flag_error("ball_y is below the vertical limit");

    turn_point: assert property (@(posedge clk_25MHZ) disable iff (reset)
        ($rose(is_ball_moving_left) && (hit_mode || miss_mode)) |->
        (hit_mode ? ball_x < coord_t'(`SCREEN_W - `BALL_SIZE) :
                    ball_x >= coord_t'(`SCREEN_W - `BALL_SIZE)))
        else flag_error("ball turned right-to-left at the wrong x");

    wall_turn: assert property (@(posedge clk_25MHZ) disable iff (reset)
        $fell(is_ball_moving_left) |-> (ball_x == '0))
        else flag_error("ball turned left-to-right away from x 0");

    // step spacing and floor tracking.
    always @(posedge clk_25MHZ or posedge reset) begin
        if (reset) begin
            cycle_count     <= 0;
            last_move       <= 0;
            gap_valid       <= 1'b0;
            prev_x          <= coord_t'(`START_X);
            prev_left       <= 1'b0;
            low_floor_seen  <= 1'b0;
            high_floor_seen <= 1'b0;
        end else begin
            cycle_count <= cycle_count + 1;
            prev_x      <= ball_x;
            prev_left   <= is_ball_moving_left;
            if (ball_x != prev_x) begin
                last_move <= cycle_count;
                gap_valid <= 1'b1;
            end
            if (is_ball_moving_left != prev_left) begin
                gap_valid <= 1'b0; // direction change restarts the count.
            end
            if (!upscale && ball_y == coord_t'(`Y_MAX_LOW)) low_floor_seen <= 1'b1;
            if (upscale && ball_y == coord_t'(`Y_MAX_HIGH)) high_floor_seen <= 1'b1;
        end
    end

    ////////////////////////////////////////
    // helpers
    ////////////////////////////////////////
    function automatic int hit_gap(input int speed);
        int step_period;
        step_period = (speed < 2) ? test_period : test_period / speed;
        return step_period + 1;
    endfunction

    function automatic bit reached(input int kind, input int value);
        case (kind)
            want_dir: return is_ball_moving_left == value[0];
            want_x:   return ball_x == coord_t'(value);
            default:  return high_floor_seen;
        endcase
    endfunction

    task automatic wait_for(input int kind, input int value, input int limit, input string what);
        int n;
        n = 0;
        if (!timed_out) begin
            @(negedge clk_25MHZ);
            while (!reached(kind, value) && n < limit) begin
                @(negedge clk_25MHZ);
                n++;
            end
            if (!reached(kind, value)) begin
                $display("timeout: no sign of %s after %0d cycles", what, limit);
                timed_out = 1'b1;
                error_count++;
            end
        end
    endtask

    task automatic send_sample(input int value);
        @(posedge clk_25MHZ);
        paddle_y     <= coord_t'(value);
        paddle_valid <= 1'b1;
        @(posedge clk_25MHZ);
        paddle_valid <= 1'b0;
    endtask

    task automatic finish_test(input string name, input int errors_before);
        if (error_count == errors_before) begin
            $display("test %s: ok", name);
            tests_ok++;
        end else begin
            $display("test %s: failed with %0d errors", name, error_count - errors_before);
            tests_failing++;
        end
    endtask

    ////////////////////////////////////////
    // stimulus
    ////////////////////////////////////////
    initial begin
        int mark;
        int diff;
        int first_y;

        void'($urandom(33));
        reset        = 1'b1;
        game_start   = 1'b0;
        upscale      = 1'b0;
        paddle_y     = '0;
        paddle_valid = 1'b0;
        repeat (5) @(posedge clk_25MHZ);
        reset      <= 1'b0;
        idle_check <= 1'b1;

        mark = error_count;
        send_sample(1000); // paddle far below every ball row.
        repeat (20) @(posedge clk_25MHZ);
        idle_check <= 1'b0;
        finish_test("reset_idle", mark);

        mark = error_count;
        @(posedge clk_25MHZ);
        game_start <= 1'b1;
        wait_for(want_dir, 1, 5, "the ball moving left");
        wait_for(want_x, 60, 1000, "ball_x at 60");
        finish_test("left_motion", mark);

        mark = error_count;
        wait_for(want_dir, 0, 3000, "a turn at the left wall");
        wait_for(want_x, 40, 2000, "ball_x at 40");
        finish_test("left_wall", mark);

        mark = error_count;
        hit_mode <= 1'b1;
        wait_for(want_x, 580, 8000, "the ball at the paddle column");
        diff    = 2 + ($urandom % 7);
        first_y = int'(ball_y) + ($urandom % 20);
        send_sample(first_y);
        send_sample(first_y + diff);
        wait_for(want_dir, 1, 100, "a bounce off the paddle");
        hit_mode     <= 1'b0;
        expected_gap <= hit_gap(diff);
        wait_for(want_x, 560, 200, "ball_x at 560 after the hit");
        finish_test("paddle_hit", mark);

        send_sample(1000);
        upscale <= 1'b1;
        wait_for(want_dir, 0, 4000, "a return to the left wall");
        expected_gap <= test_period + 1; // wall restores the base period.

        mark = error_count;
        miss_mode <= 1'b1;
        wait_for(want_dir, 1, 8000, "a turn at the right wall");
        miss_mode <= 1'b0;
        finish_test("paddle_miss", mark);

        mark = error_count;
        wait_for(want_floor, 0, 20000, "the ball on the upscaled floor");
        low_floor: assert (low_floor_seen) else flag_error("ball never landed on y 239");
        high_floor: assert (high_floor_seen) else flag_error("ball never landed on y 479");
        finish_test("vertical_bounds", mark);

        $display("tests ok: %0d, tests failing: %0d, errors: %0d",
                 tests_ok, tests_failing, error_count);
        if (error_count == 0 && !timed_out) begin
            $display("All tests passed");
        end else begin
            $display("Some tests failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== game_top.sv ====
`timescale 1ns/1ps
`default_nettype none

module game_top #(
    parameter int base_period = 270000
) (
    input  wire logic             clk_25MHZ,
    input  wire logic             reset,
    input  wire logic             game_start,
    input  wire logic             upscale,
    input  wire game_pkg::coord_t paddle_y,
    input  wire logic             paddle_valid,
    output game_pkg::coord_t      ball_x,
    output game_pkg::coord_t      ball_y,
    output logic                  is_ball_moving_left
);

    import game_pkg::*;

    coord_t paddle_pos;
    coord_t estimated_speed;
    logic   collision_detected;

    paddle_tracker u_tracker (
        .clk_25MHZ       (clk_25MHZ),
        .reset           (reset),
        .paddle_y        (paddle_y),
        .paddle_valid    (paddle_valid),
        .paddle_pos      (paddle_pos),
        .estimated_speed (estimated_speed)
    );

    hit_detector u_hit (
        .clk_25MHZ          (clk_25MHZ),
        .reset              (reset),
        .ball_x             (ball_x),
        .ball_y             (ball_y),
        .paddle_pos         (paddle_pos),
        .collision_detected (collision_detected)
    );

    ball_controller #(
        .base_period (base_period)
    ) u_ball (
        .clk_25MHZ           (clk_25MHZ),
        .reset               (reset),
        .upscale             (upscale),
        .game_start          (game_start),
        .collision_detected  (collision_detected),
        .estimated_speed     (estimated_speed),
        .ball_x              (ball_x),
        .ball_y              (ball_y),
        .is_ball_moving_left (is_ball_moving_left)
    );

endmodule

`default_nettype wire

// ==== ball_controller.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "game_consts.svh"

module ball_controller #(
    parameter int base_period = 270000
) (
    input  wire logic             clk_25MHZ,
    input  wire logic             reset,
    input  wire logic             upscale,
    input  wire logic             game_start,
    input  wire logic             collision_detected,
    input  wire game_pkg::coord_t estimated_speed,
    output game_pkg::coord_t      ball_x,
    output game_pkg::coord_t      ball_y,
    output logic                  is_ball_moving_left
);

    import game_pkg::*;

    localparam int period_w = $clog2(base_period + 1);

    ball_state_t         state;
    ball_state_t         state_next;
    coord_t              ball_x_next;
    coord_t              ball_y_next;
    vel_t                vel;
    vel_t                vel_next;
    logic [period_w-1:0] step_count;
    logic [period_w-1:0] step_count_next;
    logic [period_w-1:0] period;
    logic [period_w-1:0] period_next;
    logic [1:0]          grav_count;
    logic [1:0]          grav_count_next;

    coord_t              y_max;
    coord_t              safe_speed;
    logic [31:0]         quotient;
    logic [period_w-1:0] hit_period;
    logic signed [11:0]  y_sum;
    coord_t              y_step;
    vel_t                vel_step;
    logic                step;
    logic                move;

    assign y_max = upscale ? coord_t'(`Y_MAX_HIGH) : coord_t'(`Y_MAX_LOW);
    assign is_ball_moving_left = (state == running_left);

    assign step = (step_count >= period);

    // period after a paddle hit.
    assign safe_speed = (estimated_speed < 10'd2) ? 10'd1 : estimated_speed;
    assign quotient   = 32'(base_period) / 32'(safe_speed);
    assign hit_period = (quotient == 32'd0) ? period_w'(1) : period_w'(quotient);

    ////////////////////////////////////////
    // vertical move for one step
    ////////////////////////////////////////
    assign y_sum = $signed({2'b00, ball_y}) + 12'(vel);

    always_comb begin
        vel_step = (grav_count == 2'd3) ? vel + vel_t'(1) : vel; // gravity.
        if (y_sum >= $signed({2'b00, y_max})) begin
            y_step   = y_max;
            vel_step = -vel_step;
        end else if (y_sum <= 12'sd0) begin
            y_step   = '0;
            vel_step = -vel_step;
        end else begin
            y_step = coord_t'(y_sum);
        end
    end

    ////////////////////////////////////////
    // state machine
    ////////////////////////////////////////
    always_comb begin
        state_next      = state;
        ball_x_next     = ball_x;
        ball_y_next     = (ball_y > y_max) ? y_max : ball_y; // range shrank.
        vel_next        = vel;
        step_count_next = step_count;
        grav_count_next = grav_count;
        period_next     = period;
        move            = 1'b0;

        case (state)
            idle: begin
                step_count_next = '0;
                if (game_start) begin
                    state_next = running_left;
                end
            end

            running_right: begin
                if ((ball_x >= coord_t'(`SCREEN_W - `BALL_SIZE)) || collision_detected) begin
                    state_next      = running_left;
                    step_count_next = '0;
                end else if (step) begin
                    ball_x_next = ball_x + coord_t'(`BALL_STEP);
                    move        = 1'b1;
                end else begin
                    step_count_next = step_count + period_w'(1);
                end
            end

            running_left: begin
                if (collision_detected) begin
                    period_next = hit_period; // faster after a hit.
                end
                if (ball_x == '0) begin
                    state_next      = running_right;
                    step_count_next = '0;
                    period_next     = period_w'(base_period);
                end else if (step) begin
                    ball_x_next = (ball_x > coord_t'(`BALL_STEP)) ?
                                  ball_x - coord_t'(`BALL_STEP) : '0;
                    move        = 1'b1;
                end else begin
                    step_count_next = step_count + period_w'(1);
                end
            end

            default: begin
                state_next = idle;
            end
        endcase

        if (move) begin
            step_count_next = '0;
            grav_count_next = grav_count + 2'd1;
            ball_y_next     = y_step;
            vel_next        = vel_step;
        end
    end

    always_ff @(posedge clk_25MHZ or posedge reset) begin
        if (reset) begin
            state      <= idle;
            ball_x     <= coord_t'(`START_X);
            ball_y     <= coord_t'(`START_Y);
            vel        <= vel_t'(`START_VEL);
            step_count <= '0;
            grav_count <= '0;
            period     <= period_w'(base_period);
        end else begin
            state      <= state_next;
            ball_x     <= ball_x_next;
            ball_y     <= ball_y_next;
            vel        <= vel_next;
            step_count <= step_count_next;
            grav_count <= grav_count_next;
            period     <= period_next;
        end
    end

    ////////////////////////////////////////
    // checks
    ////////////////////////////////////////
    y_in_range: assert property (@(posedge clk_25MHZ) disable iff (reset)
        ball_y <= ($past(upscale) ? coord_t'(`Y_MAX_HIGH) : coord_t'(`Y_MAX_LOW)));

    state_legal: assert property (@(posedge clk_25MHZ) disable iff (reset)
        state inside {idle, running_right, running_left});

    period_nonzero: assert property (@(posedge clk_25MHZ) disable iff (reset)
        period != '0);

endmodule

`default_nettype wire

// ==== hit_detector.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "game_consts.svh"

module hit_detector (
    input  wire logic             clk_25MHZ,
    input  wire logic             reset,
    input  wire game_pkg::coord_t ball_x,
    input  wire game_pkg::coord_t ball_y,
    input  wire game_pkg::coord_t paddle_pos,
    output logic                  collision_detected
);

    logic [10:0] ball_right;
    logic [10:0] ball_bottom;
    logic        reach_x;
    logic        reach_top;
    logic        reach_bottom;
    logic        overlap;

    assign ball_right  = {1'b0, ball_x} + 11'(`BALL_SIZE);
    assign ball_bottom = {1'b0, ball_y} + 11'(`BALL_SIZE);

    assign reach_x = (ball_right >= 11'(`PADDLE_X));

    // paddle span is paddle_pos +/- PADDLE_HALF, offset kept on the ball side.
    assign reach_top    = (ball_bottom + 11'(`PADDLE_HALF) >= {1'b0, paddle_pos});
    assign reach_bottom = ({1'b0, ball_y} <= {1'b0, paddle_pos} + 11'(`PADDLE_HALF));

    assign overlap = reach_x && reach_top && reach_bottom;

    always_ff @(posedge clk_25MHZ or posedge reset) begin
        if (reset) begin
            collision_detected <= 1'b0;
        end else begin
            collision_detected <= overlap; // one cycle late.
        end
    end

endmodule

`default_nettype wire

// ==== paddle_tracker.sv ====
`timescale 1ns/1ps
`default_nettype none

module paddle_tracker (
    input  wire logic             clk_25MHZ,
    input  wire logic             reset,
    input  wire game_pkg::coord_t paddle_y,
    input  wire logic             paddle_valid,
    output game_pkg::coord_t      paddle_pos,
    output game_pkg::coord_t      estimated_speed
);

    import game_pkg::*;

    logic   have_sample;
    coord_t delta;

    // distance moved since the last sample.
    assign delta = (paddle_y >= paddle_pos) ? paddle_y - paddle_pos : paddle_pos - paddle_y;

    always_ff @(posedge clk_25MHZ or posedge reset) begin
        if (reset) begin
            paddle_pos      <= '0;
            estimated_speed <= '0;
            have_sample     <= 1'b0;
        end else if (paddle_valid) begin
            paddle_pos      <= paddle_y;
            estimated_speed <= have_sample ? delta : '0; // no history yet.
            have_sample     <= 1'b1;
        end
    end

    ////////////////////////////////////////
    // checks
    ////////////////////////////////////////
    outputs_hold: assert property (@(posedge clk_25MHZ) disable iff (reset)
        !$past(paddle_valid) |-> ($stable(paddle_pos) && $stable(estimated_speed)));

endmodule

`default_nettype wire

// ==== game_pkg.sv ====
`default_nettype none

package game_pkg;

    // screen coordinate, x or y.
    typedef logic [9:0] coord_t;

    // pixels per step, positive is down.
    typedef logic signed [9:0] vel_t;

    typedef enum logic [1:0] {
        idle          = 2'd0,
        running_right = 2'd1,
        running_left  = 2'd2
    } ball_state_t;

endpackage

`default_nettype wire

// ==== game_consts.svh ====
`ifndef GAME_CONSTS_SVH
`define GAME_CONSTS_SVH

////////////////////////////////////////
// screen and ball
////////////////////////////////////////
`define SCREEN_W     640
`define BALL_SIZE    20
`define BALL_STEP    4      // x pixels per step.

////////////////////////////////////////
// start condition
////////////////////////////////////////
`define START_X      100
`define START_Y      80
`define START_VEL    (-3)   // moving up at start.

// lowest y the ball may reach.
`define Y_MAX_LOW    239    // upscale low.
`define Y_MAX_HIGH   479    // upscale high.

////////////////////////////////////////
// paddle
////////////////////////////////////////
`define PADDLE_X     600    // left edge of paddle column.
`define PADDLE_HALF  30     // half height.

`endif
